// File: hw/icache_pkg.sv
package icache_pkg;

   // address and instruction widths
   localparam int ADDR_W  = 32;
   localparam int INSTR_W = 32;

   // line geometry
   localparam int WORDS_PER_LINE = 4;
   localparam int LINE_W         = WORDS_PER_LINE * INSTR_W;  // 128
   localparam int OFFSET_W       = 4;                         // byte offset in a line

   // set and way geometry
   localparam int NUM_SETS = 16;
   localparam int INDEX_W  = 4;
   localparam int NUM_WAYS = 4;
   localparam int WAY_W    = 2;

   // what is left of the pc above index and offset
   localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;        // 24

endpackage

// File: hw/icache_arrays.sv
module icache_arrays
   import icache_pkg::*;
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              flush,
   input  logic [INDEX_W-1:0]                rd_index,
   output logic [NUM_WAYS-1:0][TAG_W-1:0]    rd_tags,
   output logic [NUM_WAYS-1:0]               rd_valid,
   output logic [NUM_WAYS-1:0][LINE_W-1:0]   rd_lines,
   output logic [WAY_W-1:0]                  rd_victim,
   input  logic                              wr_en,
   input  logic [INDEX_W-1:0]                wr_index,
   input  logic [WAY_W-1:0]                  wr_way,
   input  logic [TAG_W-1:0]                  wr_tag,
   input  logic [LINE_W-1:0]                 wr_line
);

   logic [TAG_W-1:0]    tag_mem  [NUM_SETS][NUM_WAYS];
   logic [LINE_W-1:0]   line_mem [NUM_SETS][NUM_WAYS];
   logic [NUM_WAYS-1:0] valid_q  [NUM_SETS];
   logic [WAY_W-1:0]    victim_q [NUM_SETS];   // round-robin pointer per set

   logic                same_set;   // write hits the set being read
   logic [NUM_WAYS-1:0] wr_onehot;

   assign same_set  = wr_en && (wr_index == rd_index);
   assign wr_onehot = NUM_WAYS'(1) << wr_way;

   // tag and line storage
   always_ff @(posedge clk) begin
      if (wr_en) begin
         tag_mem[wr_index][wr_way]  <= wr_tag;
         line_mem[wr_index][wr_way] <= wr_line;
      end
   end

   // valid bits and victim pointers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int s = 0; s < NUM_SETS; s++) begin
            valid_q[s]  <= '0;
            victim_q[s] <= '0;
         end
      end else begin
         if (flush) begin
            for (int s = 0; s < NUM_SETS; s++) begin
               valid_q[s] <= '0;
            end
         end else if (wr_en) begin
            valid_q[wr_index] <= valid_q[wr_index] | wr_onehot;
         end
         if (wr_en) begin
            victim_q[wr_index] <= victim_q[wr_index] + WAY_W'(1);   // next way in turn
         end
      end
   end

   // registered read, a write to the same set is forwarded so the
   // reader never sees the line before its refill
   always_ff @(posedge clk) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (same_set && (wr_way == WAY_W'(w))) begin
            rd_tags[w]  <= wr_tag;
            rd_lines[w] <= wr_line;
         end else begin
            rd_tags[w]  <= tag_mem[rd_index][w];
            rd_lines[w] <= line_mem[rd_index][w];
         end
      end
      if (same_set) begin
         rd_victim <= victim_q[rd_index] + WAY_W'(1);
      end else begin
         rd_victim <= victim_q[rd_index];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_valid <= '0;
      end else if (flush) begin
         rd_valid <= '0;   // nothing survives a flush
      end else if (same_set) begin
         rd_valid <= valid_q[rd_index] | wr_onehot;
      end else begin
         rd_valid <= valid_q[rd_index];
      end
   end

   // refill control must drop the write of a response caught by a flush
   a_no_write_on_flush: assert property (
      @(posedge clk) disable iff (!rst_n)
      wr_en |-> !flush
   ) else $error("refill write in a flush cycle");

endmodule

// File: hw/icache_tag_match.sv
module icache_tag_match
   import icache_pkg::*;
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              flush,
   input  logic                              req_valid,
   output logic                              req_ready,
   input  logic [ADDR_W-1:0]                 req_pc,
   output logic [INDEX_W-1:0]                rd_index,
   input  logic [NUM_WAYS-1:0][TAG_W-1:0]    rd_tags,
   input  logic [NUM_WAYS-1:0]               rd_valid,
   input  logic [NUM_WAYS-1:0][LINE_W-1:0]   rd_lines,
   output logic                              s1_valid,
   input  logic                              s1_ready,
   output logic [ADDR_W-1:0]                 s1_pc,
   output logic                              s1_hit,
   output logic [WAY_W-1:0]                  s1_way,
   output logic [INSTR_W-1:0]                s1_instr
);

   logic                                   v_q;
   logic [ADDR_W-1:0]                      pc_q;
   logic                                   take;
   logic [NUM_WAYS-1:0]                    hit_vec;   // one bit per way, at most one set
   logic [WORDS_PER_LINE-1:0][INSTR_W-1:0] hit_words;

   // no new request in a flush cycle, it would be dropped anyway
   assign req_ready = (!v_q || s1_ready) && !flush;
   assign take      = req_valid && req_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         v_q <= 1'b0;
      end else if (flush) begin
         v_q <= 1'b0;
      end else if (take) begin
         v_q <= 1'b1;
      end else if (s1_ready) begin
         v_q <= 1'b0;   // item moved on, nothing behind it
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         pc_q <= req_pc;
      end
   end

   // stalled item rereads its own set, otherwise look up the incoming pc
   always_comb begin
      if (v_q && !s1_ready) begin
         rd_index = pc_q[OFFSET_W +: INDEX_W];
      end else begin
         rd_index = req_pc[OFFSET_W +: INDEX_W];
      end
   end

   // tag compare, invalid ways never hit
   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         hit_vec[w] = rd_valid[w] && (rd_tags[w] == pc_q[ADDR_W-1 -: TAG_W]);
      end
   end

   always_comb begin
      s1_way = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (hit_vec[w]) begin
            s1_way = WAY_W'(w);
         end
      end
   end

   assign hit_words = rd_lines[s1_way];
   assign s1_instr  = hit_words[pc_q[OFFSET_W-1:2]];   // word within the line
   assign s1_hit    = |hit_vec;
   assign s1_valid  = v_q;
   assign s1_pc     = pc_q;

   // a refill never installs a line that is already present in the set
   a_hit_onehot: assert property (
      @(posedge clk) disable iff (!rst_n)
      v_q |-> $onehot0(hit_vec)
   ) else $error("tag hit in more than one way");

endmodule

// File: hw/icache_refill_ctrl.sv
module icache_refill_ctrl
   import icache_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flush,
   input  logic                 s1_valid,
   output logic                 s1_ready,
   input  logic [ADDR_W-1:0]    s1_pc,
   input  logic                 s1_hit,
   input  logic [WAY_W-1:0]     s1_way,
   input  logic [INSTR_W-1:0]   s1_instr,
   input  logic [WAY_W-1:0]     rd_victim,
   output logic                 wr_en,
   output logic [INDEX_W-1:0]   wr_index,
   output logic [WAY_W-1:0]     wr_way,
   output logic [TAG_W-1:0]     wr_tag,
   output logic [LINE_W-1:0]    wr_line,
   output logic                 mem_req,
   input  logic                 mem_accept,
   output logic [ADDR_W-1:0]    mem_addr,
   input  logic                 mem_resp,
   input  logic [LINE_W-1:0]    mem_data,
   output logic                 out_valid,
   input  logic                 out_ready,
   output logic [ADDR_W-1:0]    out_pc,
   output logic [INSTR_W-1:0]   out_instr
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_REQ,     // asking memory for the line
      S_WAIT,    // accepted, response pending
      S_DRAIN    // flushed while pending, response is thrown away
   } state_e;

   state_e                                 state_q, state_n;
   logic                                   out_valid_q;
   logic [ADDR_W-1:0]                      out_pc_q;
   logic [INSTR_W-1:0]                     out_instr_q;
   logic [ADDR_W-1:0]                      miss_pc;
   logic [WAY_W-1:0]                       miss_way;
   logic                                   fill_live;   // miss_pc line is resident
   logic                                   out_free;
   logic                                   take;
   logic                                   take_hit;
   logic                                   take_miss;
   logic [WORDS_PER_LINE-1:0][INSTR_W-1:0] resp_words;

   assign out_free  = !out_valid_q || out_ready;
   // nothing is taken while a miss is open or in the refill write cycle
   assign s1_ready  = (state_q == S_IDLE) && out_free && !flush;
   assign take      = s1_valid && s1_ready;
   assign take_hit  = take && s1_hit;
   assign take_miss = take && !s1_hit;

   always_comb begin
      state_n = state_q;
      case (state_q)
         S_IDLE:  if (take_miss) state_n = S_REQ;
         S_REQ:   if (mem_accept) state_n = S_WAIT;
         S_WAIT:  if (mem_resp) state_n = S_IDLE;
         S_DRAIN: if (mem_resp) state_n = S_IDLE;
         default: state_n = S_IDLE;
      endcase
      // a flush keeps only the knowledge that a response is still owed
      if (flush) begin
         if (state_n == S_WAIT || state_n == S_DRAIN) begin
            state_n = S_DRAIN;
         end else begin
            state_n = S_IDLE;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= S_IDLE;
      end else begin
         state_q <= state_n;
      end
   end

   always_ff @(posedge clk) begin
      if (take_miss) begin
         miss_pc  <= s1_pc;
         miss_way <= rd_victim;   // victim of the missing set
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fill_live <= 1'b0;
      end else if (flush || take_miss) begin
         fill_live <= 1'b0;
      end else if (wr_en) begin
         fill_live <= 1'b1;
      end
   end

   assign mem_req  = (state_q == S_REQ);
   assign mem_addr = {miss_pc[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

   // refill write, a flushed response is never written
   assign wr_en    = (state_q == S_WAIT) && mem_resp && !flush;
   assign wr_index = miss_pc[OFFSET_W +: INDEX_W];
   assign wr_tag   = miss_pc[ADDR_W-1 -: TAG_W];
   assign wr_way   = miss_way;
   assign wr_line  = mem_data;

   assign resp_words = mem_data;

   // output register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid_q <= 1'b0;
      end else if (flush) begin
         out_valid_q <= 1'b0;
      end else if (take_hit || wr_en) begin
         out_valid_q <= 1'b1;
      end else if (out_ready) begin
         out_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take_hit) begin
         out_pc_q    <= s1_pc;
         out_instr_q <= s1_instr;
      end else if (wr_en) begin
         out_pc_q    <= miss_pc;
         out_instr_q <= resp_words[miss_pc[OFFSET_W-1:2]];   // missed word
      end
   end

   assign out_valid = out_valid_q;
   assign out_pc    = out_pc_q;
   assign out_instr = out_instr_q;

   a_mem_req_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      mem_req && !mem_accept && !flush |=> mem_req && $stable(mem_addr)
   ) else $error("memory request dropped or changed before accept");

   a_out_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready && !flush |=>
         out_valid && $stable(out_pc) && $stable(out_instr)
   ) else $error("output changed while stalled");

   // stage 1 must see a refilled line right away, in the way it went to
   a_refill_visible: assert property (
      @(posedge clk) disable iff (!rst_n || flush)
      take && fill_live && (s1_pc[ADDR_W-1:OFFSET_W] == miss_pc[ADDR_W-1:OFFSET_W])
         |-> s1_hit && (s1_way == miss_way)
   ) else $error("refilled line not seen by tag match");

endmodule

// File: hw/icache_top.sv
module icache_top
   import icache_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flush,
   input  logic                 req_valid,
   output logic                 req_ready,
   input  logic [ADDR_W-1:0]    req_pc,
   output logic                 out_valid,
   input  logic                 out_ready,
   output logic [ADDR_W-1:0]    out_pc,
   output logic [INSTR_W-1:0]   out_instr,
   output logic                 mem_req,
   input  logic                 mem_accept,
   output logic [ADDR_W-1:0]    mem_addr,
   input  logic                 mem_resp,
   input  logic [LINE_W-1:0]    mem_data
);

   // array read side
   logic [INDEX_W-1:0]                rd_index;
   logic [NUM_WAYS-1:0][TAG_W-1:0]    rd_tags;
   logic [NUM_WAYS-1:0]               rd_valid;
   logic [NUM_WAYS-1:0][LINE_W-1:0]   rd_lines;
   logic [WAY_W-1:0]                  rd_victim;

   // array refill side
   logic                              wr_en;
   logic [INDEX_W-1:0]                wr_index;
   logic [WAY_W-1:0]                  wr_way;
   logic [TAG_W-1:0]                  wr_tag;
   logic [LINE_W-1:0]                 wr_line;

   // stage 1 to stage 2
   logic                              s1_valid;
   logic                              s1_ready;
   logic [ADDR_W-1:0]                 s1_pc;
   logic                              s1_hit;
   logic [WAY_W-1:0]                  s1_way;
   logic [INSTR_W-1:0]                s1_instr;

   icache_arrays arrays_inst (.*);

   icache_tag_match tag_match_inst (.*);

   icache_refill_ctrl refill_ctrl_inst (.*);

endmodule

// File: sim/icache_mem_model.sv
module icache_mem_model
   import icache_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                mem_req,
   input  logic [ADDR_W-1:0]   mem_addr,
   output logic                mem_accept,
   output logic                mem_resp,
   output logic [LINE_W-1:0]   mem_data,
   output int                  accept_count
);
   timeunit 1ns;
   timeprecision 100ps;

   integer            seed = 32'h6f4e3a89;
   int                wait_cycles;
   logic [ADDR_W-1:0] line_addr;

   initial begin
      mem_accept   = 1'b0;
      mem_resp     = 1'b0;
      mem_data     = '0;
      accept_count = 0;
      forever begin
         @(posedge clk);
         #1;
         if (rst_n && mem_req) begin
            wait_cycles = {$random(seed)} % 4;   // accept after 0 to 3 cycles
            repeat (wait_cycles) begin
               @(posedge clk);
               #1;
            end
            if (mem_req) begin   // a flush may have withdrawn the request
               mem_accept = 1'b1;
               line_addr  = mem_addr;
               @(posedge clk);
               #1;
               mem_accept = 1'b0;
               accept_count++;
               // response lands 2 to 5 cycles after the accept
               wait_cycles = 1 + {$random(seed)} % 4;
               repeat (wait_cycles) begin
                  @(posedge clk);
                  #1;
               end
               mem_resp = 1'b1;
               for (int w = 0; w < WORDS_PER_LINE; w++) begin
                  mem_data[w*INSTR_W +: INSTR_W] = (line_addr + 4 * w) ^ 32'h5a5a_0000;
               end
               @(posedge clk);
               #1;
               mem_resp = 1'b0;
            end
         end
      end
   end

endmodule

// File: sim/icache_tb.sv
module icache_tb
   import icache_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_NS      = 10;
   localparam int COLD_LINES  = 3;
   localparam int BP_REQS     = 40;
   // two passes over the cold lines, replacement, flush, back-pressure
   localparam int TOTAL_REQS  = 2 * COLD_LINES * WORDS_PER_LINE + 7 + 2 + BP_REQS;
   localparam int WATCHDOG_NS = TOTAL_REQS * 200 * CLK_NS;

   logic               clk, rst_n, flush;
   logic               req_valid, req_ready;
   logic [ADDR_W-1:0]  req_pc;
   logic               out_valid, out_ready;
   logic [ADDR_W-1:0]  out_pc;
   logic [INSTR_W-1:0] out_instr;
   logic               mem_req, mem_accept, mem_resp;
   logic [ADDR_W-1:0]  mem_addr;
   logic [LINE_W-1:0]  mem_data;
   int                 mem_count;

   logic [ADDR_W-1:0]  exp_q[$];   // accepted pcs not yet delivered
   logic [ADDR_W-1:0]  exp_front;
   int                 exp_count;
   logic               quiet_window = 1'b0;
   integer             seed = 32'h6f4e3a89;

   icache_top icache_top_inst (.*);
   icache_mem_model mem_model_inst (.*, .accept_count(mem_count));

   always #(CLK_NS / 2) clk = ~clk;

   function automatic logic [INSTR_W-1:0] rule_word(input logic [ADDR_W-1:0] pc);
      return {pc[ADDR_W-1:2], 2'b00} ^ 32'h5a5a_0000;
   endfunction

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic value_error(input string msg);
      $display("[ERROR] %0t: %s", $time, msg);
      abort_run();
   endtask

   task automatic fetch(input logic [ADDR_W-1:0] pc);
      req_valid = 1'b1;
      req_pc    = pc;
      do begin
         @(posedge clk);
      end while (!req_ready);
      #1;
      req_valid = 1'b0;
   endtask

   task automatic drain();
      while (exp_q.size() != 0 || out_valid) begin
         @(posedge clk);
         #1;
      end
   endtask

   // each line entered at a different word
   task automatic fetch_cold_lines();
      for (int l = 0; l < COLD_LINES; l++) begin
         for (int k = 0; k < WORDS_PER_LINE; k++) begin
            fetch(32'h0000_1000 + l * 32'h0000_1040 + 4 * ((k + l) % WORDS_PER_LINE));
         end
      end
   endtask

   task automatic check_count(input int expected, input string phase);
      a_mem_count: assert (mem_count == expected)
         else value_error($sformatf("%s: %0d memory requests, expected %0d",
                                    phase, mem_count, expected));
   endtask

   always @(posedge clk) begin
      quiet_window <= !rst_n;
      if (!rst_n || flush) begin
         exp_q.delete();
      end else begin
         if (out_valid && out_ready && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
         end
         if (req_valid && req_ready) begin
            exp_q.push_back(req_pc);
         end
      end
      exp_front <= (exp_q.size() != 0) ? exp_q[0] : '0;
      exp_count <= exp_q.size();
   end

   a_reset_quiet: assert property (@(posedge clk) quiet_window |-> !out_valid && !mem_req)
      else value_error("out_valid or mem_req high in or right after reset");

   a_out_order: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && out_ready |-> exp_count != 0 && out_pc == exp_front)
      else value_error($sformatf("output pc %h, expected %h (%0d pending)",
                                 $sampled(out_pc), $sampled(exp_front), $sampled(exp_count)));

   a_out_data: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && out_ready |-> out_instr == rule_word(out_pc))
      else value_error($sformatf("pc %h gave instr %h, expected %h", $sampled(out_pc),
                                 $sampled(out_instr), rule_word($sampled(out_pc))));

   // the missed item is the oldest one still owed
   a_mem_line: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req |-> exp_count != 0 && mem_addr[OFFSET_W-1:0] == '0 &&
         mem_addr[ADDR_W-1:OFFSET_W] == exp_front[ADDR_W-1:OFFSET_W])
      else value_error($sformatf("memory address %h, expected line of %h",
                                 $sampled(mem_addr), $sampled(exp_front)));

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the cache stopped making progress", WATCHDOG_NS);
      abort_run();
   end

   initial begin
      int          base;
      int          issued;
      logic [31:0] rnd;
      logic        sent;
      clk       = 1'b0;
      rst_n     = 1'b0;
      flush     = 1'b0;
      req_valid = 1'b0;
      req_pc    = '0;
      out_ready = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      fetch_cold_lines();
      drain();
      check_count(COLD_LINES, "cold misses");
      fetch_cold_lines();   // all hits now
      drain();
      check_count(COLD_LINES, "warm hits");

      // tags A to E in set 12, E takes the way of A
      base = mem_count;
      for (int t = 0; t < 5; t++) begin
         fetch(32'h0000_10c0 + t * 32'h0000_0100);
      end
      drain();
      check_count(base + 5, "replacement fill");
      fetch(32'h0000_11c0);
      drain();
      check_count(base + 5, "replacement keeps B");
      fetch(32'h0000_10c4);
      drain();
      check_count(base + 6, "replacement evicts A");

      issued = 0;
      while (issued < BP_REQS) begin
         rnd       = $random(seed);
         out_ready = rnd[8];
         if (!req_valid) begin
            req_valid = 1'b1;
            req_pc    = 32'h0000_4000 | {24'h0, rnd[7:2], 2'b00};   // 16 lines, one per set
         end
         @(posedge clk);
         sent = req_ready;
         #1;
         if (sent) begin
            req_valid = 1'b0;
            issued++;
         end
      end
      out_ready = 1'b1;
      drain();

      base = mem_count;
      fetch(32'h0000_1004);
      drain();
      check_count(base, "hit before flush");
      flush = 1'b1;
      @(posedge clk);
      #1;
      flush = 1'b0;
      fetch(32'h0000_1008);
      drain();
      check_count(base + 1, "refetch after flush");

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: icache.f
hw/icache_pkg.sv
hw/icache_arrays.sv
hw/icache_tag_match.sv
hw/icache_refill_ctrl.sv
hw/icache_top.sv
sim/icache_mem_model.sv
sim/icache_tb.sv
